// ==== include/mem_config.svh ====
//////////////////////////////////////////////////////////////////////
// Sizing of the tagged memory model
// MEM_TAG_BITS must be able to hold MEM_NUM_TAGS, as tag 0 means none
// MEM_LINES sets the valid address range, MEM_LINES * 8 bytes
//////////////////////////////////////////////////////////////////////

`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Number of 64-bit blocks held in the array
`define MEM_LINES 64

// Outstanding operations, tags run 1..MEM_NUM_TAGS
`define MEM_NUM_TAGS 4

// Countdown loaded when a request is accepted
`define MEM_LATENCY 6

// Width of a transaction tag
`define MEM_TAG_BITS 4

`endif

// ==== hdl/mem_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the tagged memory model
// Tag width comes from mem_config.svh
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    typedef logic [31:0]               addr_t;      // Byte address
    typedef logic [63:0]               mem_block_t; // One memory block
    typedef logic [`MEM_TAG_BITS-1:0]  mem_tag_t;   // 0 = no tag

    // Access size inside a block
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } mem_size_e;

    // Request command, code 3 is unused
    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_load  = 2'd1,
        cmd_store = 2'd2
    } mem_cmd_e;

    // Life of one tag
    typedef enum logic [1:0] {
        tag_free     = 2'd0,
        tag_busy     = 2'd1, // Latency still running
        tag_wait_bus = 2'd2  // Load done, waiting for the data bus
    } tag_state_e;

endpackage

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
//////////////////////////////////////////////////////////////////////
// Request bus from the processor side into the memory blocks
// No handshake, a request lives for exactly one cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface mem_req_if
    import mem_pkg::*;
();

    addr_t      addr;    // Byte address
    mem_block_t data;    // Store data, low lanes used for narrow stores
    mem_size_e  size;    // Access width
    mem_cmd_e   command; // None, load or store

    // Driven by the top level
    modport source (output addr, data, size, command);

    // Read by the array, the tag FSM and the load buffer
    modport sink (input addr, data, size, command);

endinterface

`default_nettype wire

// ==== hdl/mem_lane_array.sv ====
//////////////////////////////////////////////////////////////////////
// Block storage with byte lane merge on stores
// Lanes must be naturally aligned, low address bits pick the lane
// Address bits above the array size are ignored here
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module mem_lane_array
    import mem_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    mem_req_if.sink     req,
    input  logic        grant,      // Request accepted this cycle
    output mem_block_t  lane_rdata  // Extracted lane, zero filled
);

    localparam int IDX_BITS = $clog2(`MEM_LINES);

    mem_block_t mem_lines [`MEM_LINES];

    logic [IDX_BITS-1:0] line_idx;
    logic [5:0]          byte_off; // Bit offset of the addressed byte
    logic [5:0]          half_off; // Bit offset of the addressed half
    logic [5:0]          word_off; // Bit offset of the addressed word
    mem_block_t          cur_block;
    mem_block_t          merged_block;

    assign line_idx  = req.addr[3 +: IDX_BITS];
    assign byte_off  = {req.addr[2:0], 3'b000};
    assign half_off  = {req.addr[2:1], 4'b0000};
    assign word_off  = {req.addr[2], 5'b00000};
    assign cur_block = mem_lines[line_idx];

    //////////////////////////////////////////////////////////////////////
    // Load lane extraction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req.size)
            size_byte:   lane_rdata = {56'b0, cur_block[byte_off +: 8]};
            size_half:   lane_rdata = {48'b0, cur_block[half_off +: 16]};
            size_word:   lane_rdata = {32'b0, cur_block[word_off +: 32]};
            default:     lane_rdata = cur_block; // Double
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Store merge
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        merged_block = cur_block; // Untouched lanes keep old data
        case (req.size)
            size_byte:   merged_block[byte_off +: 8]  = req.data[7:0];
            size_half:   merged_block[half_off +: 16] = req.data[15:0];
            size_word:   merged_block[word_off +: 32] = req.data[31:0];
            default:     merged_block = req.data;
        endcase
    end

    // Only an accepted store may touch the array
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                mem_lines[i] <= '0;
            end
        end else if (grant && (req.command == cmd_store)) begin
            mem_lines[line_idx] <= merged_block;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_tag_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// Tag allocation and release, one small FSM per tag
// Lowest free tag wins a grant, lowest expired load wins the data bus
// One release per cycle, no back-pressure on the data bus
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module mem_tag_fsm
    import mem_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    mem_req_if.sink                  req,
    input  logic [`MEM_NUM_TAGS:1]   timer_done,      // Count at zero, per tag
    output logic [`MEM_NUM_TAGS:1]   timer_start,     // One-hot load of a counter
    output logic                     grant,           // Request accepted
    output mem_tag_t                 grant_tag,       // Tag given to it
    output mem_tag_t                 release_tag,     // Load sent to the bus, 0 = none
    output mem_tag_t                 transaction_tag,
    output mem_tag_t                 data_tag
);

    localparam addr_t MEM_BYTES = addr_t'(`MEM_LINES * 8);

    tag_state_e tag_state   [1:`MEM_NUM_TAGS];
    logic       tag_is_load [1:`MEM_NUM_TAGS]; // Picks the exit from tag_busy

    logic in_range;
    logic is_access;
    logic tag_ready [1:`MEM_NUM_TAGS]; // Load may drive the bus this cycle

    assign in_range  = (req.addr < MEM_BYTES);
    assign is_access = (req.command == cmd_load) || (req.command == cmd_store);
    assign grant     = is_access && in_range && (grant_tag != '0);

    always_comb begin
        grant_tag   = '0;
        release_tag = '0;
        // Walk downward so the lowest number is left standing
        for (int i = `MEM_NUM_TAGS; i >= 1; i--) begin
            // An expired busy load already counts as waiting for the bus
            tag_ready[i] = timer_done[i] &&
                           ((tag_state[i] == tag_wait_bus) ||
                            ((tag_state[i] == tag_busy) && tag_is_load[i]));
            if (tag_state[i] == tag_free) grant_tag = mem_tag_t'(i);
            if (tag_ready[i])             release_tag = mem_tag_t'(i);
        end
    end

    always_comb begin
        for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
            timer_start[i] = grant && (grant_tag == mem_tag_t'(i));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Per-tag state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
                tag_state[i]   <= tag_free;
                tag_is_load[i] <= 1'b0;
            end
        end else begin
            for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
                case (tag_state[i])
                    tag_free: if (timer_start[i]) begin
                        tag_state[i]   <= tag_busy;
                        tag_is_load[i] <= (req.command == cmd_load);
                    end
                    tag_busy: if (timer_done[i]) begin
                        if (!tag_is_load[i] || (release_tag == mem_tag_t'(i)))
                            tag_state[i] <= tag_free;     // Store, or load sent now
                        else
                            tag_state[i] <= tag_wait_bus; // Bus taken by a lower tag
                    end
                    tag_wait_bus: if (release_tag == mem_tag_t'(i)) begin
                        tag_state[i] <= tag_free;
                    end
                    default: tag_state[i] <= tag_free;
                endcase
            end
        end
    end

    // Both output tags last one cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            transaction_tag <= '0;
            data_tag        <= '0;
        end else begin
            transaction_tag <= grant ? grant_tag : '0;
            data_tag        <= release_tag;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_latency_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Per-tag latency countdown
// A start always reloads, even over a running count
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module mem_latency_timer (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic [`MEM_NUM_TAGS:1]  timer_start, // One-hot, from the tag FSM
    output logic [`MEM_NUM_TAGS:1]  timer_done   // High while the count is zero
);

    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);
    localparam logic [CNT_BITS-1:0] LATENCY = CNT_BITS'(`MEM_LATENCY);

    logic [CNT_BITS-1:0] count [1:`MEM_NUM_TAGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
                if (timer_start[i]) begin
                    count[i] <= LATENCY;
                end else if (count[i] != '0) begin
                    count[i] <= count[i] - 1'b1; // Holds at zero
                end
            end
        end
    end

    // Idle counters sit at zero, so done is also high for free tags
    always_comb begin
        for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
            timer_done[i] = (count[i] == '0);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_load_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Holds load data per tag until the data bus is free
// Data is captured at acceptance, later stores do not update it
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module mem_load_buffer
    import mem_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    mem_req_if.sink     req,          // Command only
    input  logic        grant,
    input  mem_tag_t    grant_tag,
    input  mem_block_t  lane_rdata,   // Extracted lane from the array
    input  mem_tag_t    release_tag,  // 0 = nothing on the bus
    output mem_block_t  rdata
);

    mem_block_t entry [1:`MEM_NUM_TAGS];

    logic capture;

    assign capture = grant && (req.command == cmd_load);

    // grant_tag is never zero while grant is high
    always_ff @(posedge clock) begin
        if (capture) begin
            entry[grant_tag] <= lane_rdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data bus register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (release_tag != '0) begin
            rdata <= entry[release_tag]; // Lines up with data_tag
        end else begin
            rdata <= '0;                 // Quiet bus
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tagged_memory.sv ====
//////////////////////////////////////////////////////////////////////
// Tagged pipelined memory, top level
// Tag 0 on transaction_tag means rejected, the caller must retry
// Loads return after MEM_LATENCY+1 edges when the bus is free
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module tagged_memory
    import mem_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  addr_t       addr,
    input  mem_block_t  wdata,
    input  mem_size_e   size,
    input  mem_cmd_e    command,
    output mem_tag_t    transaction_tag, // Tag for this request, 0 = refused
    output mem_block_t  rdata,           // Load data
    output mem_tag_t    data_tag         // Tag of rdata, 0 = no value
);

    logic                    grant;
    mem_tag_t                grant_tag;
    mem_tag_t                release_tag;
    logic [`MEM_NUM_TAGS:1]  timer_start;
    logic [`MEM_NUM_TAGS:1]  timer_done;
    mem_block_t              lane_rdata;

    mem_req_if req_bus ();

    // Plain ports onto the request bus
    assign req_bus.addr    = addr;
    assign req_bus.data    = wdata;
    assign req_bus.size    = size;
    assign req_bus.command = command;

    mem_tag_fsm tag_fsm_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .req             (req_bus),
        .timer_done      (timer_done),
        .timer_start     (timer_start),
        .grant           (grant),
        .grant_tag       (grant_tag),
        .release_tag     (release_tag),
        .transaction_tag (transaction_tag),
        .data_tag        (data_tag)
    );

    mem_latency_timer latency_timer_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    mem_lane_array lane_array_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .req        (req_bus),
        .grant      (grant),
        .lane_rdata (lane_rdata)
    );

    mem_load_buffer load_buffer_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .req         (req_bus),
        .grant       (grant),
        .grant_tag   (grant_tag),
        .lane_rdata  (lane_rdata),
        .release_tag (release_tag),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

// ==== tests/tagged_memory_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the tagged memory, requests come from the golden file
// Run from the project root, the golden file path is relative to it
// Release order is modelled here, one load per cycle, lowest tag first
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_config.svh"

module tagged_memory_tb
    import mem_pkg::*;
();

    localparam int NUM_FIELDS = 7;  // Columns per golden line
    localparam int MAX_LINES  = 48;

    logic        clock;
    logic        rst_n;
    addr_t       addr;
    mem_block_t  wdata;
    mem_size_e   size;
    mem_cmd_e    command;
    mem_tag_t    transaction_tag;
    mem_block_t  rdata;
    mem_tag_t    data_tag;

    logic [63:0] golden [NUM_FIELDS * MAX_LINES];

    // Outstanding tags
    logic        load_out   [1:`MEM_NUM_TAGS]; // Load still owes its data
    mem_block_t  load_val   [1:`MEM_NUM_TAGS]; // Expected load data
    int          load_due   [1:`MEM_NUM_TAGS]; // First cycle its data may show
    int          busy_until [1:`MEM_NUM_TAGS]; // Store tag free from this cycle

    // Request sampled at the coming rising edge
    logic        pend_valid;
    mem_cmd_e    pend_cmd;
    mem_tag_t    pend_tag;
    mem_block_t  pend_val;

    int cycle;        // Falling edges since reset release
    int cycle_limit;
    int num_lines;
    int errors;
    int checks;

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    tagged_memory tagged_memory_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .addr            (addr),
        .wdata           (wdata),
        .size            (size),
        .command         (command),
        .transaction_tag (transaction_tag),
        .rdata           (rdata),
        .data_tag        (data_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic flag_error(input string msg);
        errors++;
        $display("FAIL at time %0t: %s", $time, msg);
    endtask

    task automatic drive_idle();
        command    = cmd_none;
        size       = size_byte;
        addr       = '0;
        wdata      = '0;
        pend_valid = 1'b0;
    endtask

    // Drives one golden line and keeps what it should return
    task automatic send_request(input int base);
        command    = mem_cmd_e'(golden[base][1:0]);
        size       = mem_size_e'(golden[base + 1][1:0]);
        addr       = golden[base + 2][31:0];
        wdata      = golden[base + 3];
        pend_val   = golden[base + 4];
        pend_tag   = golden[base + 5][`MEM_TAG_BITS-1:0];
        pend_cmd   = command;
        pend_valid = (command == cmd_load) || (command == cmd_store);
    endtask

    task automatic check_outputs();
        mem_tag_t   exp_tag;
        mem_tag_t   exp_data_tag;
        mem_block_t exp_rdata;
        int         t;
        exp_tag      = pend_valid ? pend_tag : mem_tag_t'(0);
        exp_data_tag = '0;
        exp_rdata    = '0;
        t            = int'(pend_tag);
        checks      += 3;
        if (transaction_tag != exp_tag) begin
            flag_error($sformatf("transaction_tag %0d, expected %0d", transaction_tag, exp_tag));
        end
        // Book the accepted request, grant check comes before this cycle's release
        if (pend_valid && (t != 0)) begin
            if (load_out[t] || (cycle < busy_until[t])) begin
                flag_error($sformatf("tag %0d granted while still busy", t));
            end
            if (pend_cmd == cmd_load) begin
                load_out[t] = 1'b1;
                load_val[t] = pend_val;
                load_due[t] = cycle + `MEM_LATENCY + 1;
            end else begin
                busy_until[t] = cycle + `MEM_LATENCY + 2; // Grantable one edge after release
            end
        end
        pend_valid = 1'b0;
        for (int i = `MEM_NUM_TAGS; i >= 1; i--) begin
            if (load_out[i] && (load_due[i] <= cycle)) exp_data_tag = mem_tag_t'(i);
        end
        if (exp_data_tag != '0) begin
            exp_rdata              = load_val[exp_data_tag];
            load_out[exp_data_tag] = 1'b0; // Free once on the bus
        end
        if (data_tag != exp_data_tag) begin
            flag_error($sformatf("data_tag %0d, expected %0d", data_tag, exp_data_tag));
        end
        if (rdata != exp_rdata) begin
            flag_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    task automatic step();
        @(negedge clock);
        cycle++;
        check_outputs();
    endtask

    function automatic logic loads_pending();
        logic pending;
        pending = 1'b0;
        for (int i = 1; i <= `MEM_NUM_TAGS; i++) pending |= load_out[i];
        return pending;
    endfunction

    // Ends a run that goes past the cycle limit
    initial begin
        wait (rst_n === 1'b1);
        while (cycle <= cycle_limit) begin
            @(posedge clock);
        end
        $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int base;
        int idle;
        int line_errors;
        rst_n     = 1'b0;
        drive_idle();
        errors    = 0;
        checks    = 0;
        cycle     = 0;
        num_lines = 0;
        for (int i = 1; i <= `MEM_NUM_TAGS; i++) begin
            load_out[i]   = 1'b0;
            load_val[i]   = '0;
            load_due[i]   = 0;
            busy_until[i] = 0;
        end
        // Upper half marks slots that the file does not reach
        for (int i = 0; i < NUM_FIELDS * MAX_LINES; i++) begin
            golden[i] = {32'hffff_ffff, 32'(i)};
        end
        $readmemh("tests/tagged_memory_golden.txt", golden);
        while ((num_lines < MAX_LINES) && (golden[num_lines * NUM_FIELDS][63:2] == '0)) begin
            num_lines++;
        end
        cycle_limit = 40 * num_lines + 200;
        if (num_lines == 0) begin
            errors++;
            $display("The golden file is missing or holds no requests");
        end

        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        for (int n = 0; n < num_lines; n++) begin
            base        = n * NUM_FIELDS;
            idle        = int'(golden[base + 6]);
            line_errors = errors;
            send_request(base);
            step();
            repeat (idle) begin
                drive_idle();
                step();
            end
            $display("request %0d: cmd %0d addr %h, %s", n + 1, golden[base][1:0],
                     golden[base + 2][31:0], (errors == line_errors) ? "ok" : "mismatch");
        end

        // Drain the data bus, then it must stay quiet
        drive_idle();
        while (loads_pending()) step();
        repeat (2) step();

        $display("%0d requests, %0d checks, %0d errors", num_lines, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tagged_memory_golden.txt ====
// cmd (1 load, 2 store) size (0 byte, 1 half, 2 word, 3 double) address write_data
// expected_load_data expected_transaction_tag idle_cycles_after_request
1 3 00000000 0000000000000000 0000000000000000 1 8
1 3 000001f8 0000000000000000 0000000000000000 1 8
2 3 00000040 1122334455667788 0000000000000000 1 8
2 2 00000044 ffffffffcafef00d 0000000000000000 1 8
2 0 00000041 00000000000000aa 0000000000000000 1 8
2 1 00000042 000000000000beef 0000000000000000 1 8
1 3 00000040 0000000000000000 cafef00dbeefaa88 1 8
1 0 00000047 0000000000000000 00000000000000ca 1 8
1 1 00000042 0000000000000000 000000000000beef 1 8
1 0 00000041 0000000000000000 00000000000000aa 1 0
1 2 00000044 0000000000000000 00000000cafef00d 2 0
1 1 00000046 0000000000000000 000000000000cafe 3 0
1 0 00000040 0000000000000000 0000000000000088 4 0
2 3 00000040 ffffffffffffffff 0000000000000000 0 3
1 2 00000040 0000000000000000 00000000beefaa88 1 0
1 1 00000044 0000000000000000 000000000000f00d 2 8
2 3 00000008 0123456789abcdef 0000000000000000 1 8
2 3 00000208 5a5a5a5a5a5a5a5a 0000000000000000 0 8
1 3 00000008 0000000000000000 0123456789abcdef 1 8
1 3 00000040 0000000000000000 cafef00dbeefaa88 1 8

// ==== verilog.f ====
+incdir+include
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/mem_lane_array.sv
hdl/mem_tag_fsm.sv
hdl/mem_latency_timer.sv
hdl/mem_load_buffer.sv
hdl/tagged_memory.sv
tests/tagged_memory_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the tagged memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tagged_memory_tb -f verilog.f --Mdir obj_dir
output=$(./obj_dir/Vtagged_memory_tb)
echo "$output"

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
